// File: rvfetch.f
+incdir+logic
logic/rvfetch_pkg.sv
logic/fetch_if.sv
logic/refill_if.sv
logic/pc_gen.sv
logic/icache.sv
logic/mem_port.sv
logic/rvfetch_top.sv
test/tb_clock.sv
test/rvfetch_tb.sv

// File: Bender.yml
package:
  name: rvfetch

sources:
  - include_dirs:
      - logic
    files:
      - logic/rvfetch_pkg.sv
      - logic/fetch_if.sv
      - logic/refill_if.sv
      - logic/pc_gen.sv
      - logic/icache.sv
      - logic/mem_port.sv
      - logic/rvfetch_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - test/tb_clock.sv
      - test/rvfetch_tb.sv

// File: test/rvfetch_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvfetch_defines.svh"

module rvfetch_tb;

  localparam int MAX_CYCLES   = 6000;
  localparam int WAIT_LIMIT   = 100;
  localparam int LOOP_LINES   = 8;   // loop fits in the cache without evictions
  localparam int MAX_REDIRECT = 6;
  localparam rvfetch_pkg::addr_t LOOP_LAST = `RESET_PC + LOOP_LINES * `LINE_BYTES - 4;
  localparam rvfetch_pkg::addr_t DATA_BASE = 64'h0000_0000_4000_0000;

  logic                 clk;
  logic                 rst_n;
  logic                 redirect_valid;
  rvfetch_pkg::addr_t   redirect_pc;
  logic                 stall;
  rvfetch_pkg::inst_t   inst;
  rvfetch_pkg::addr_t   inst_pc;
  logic                 inst_valid;
  logic                 data_req;
  rvfetch_pkg::addr_t   data_addr;
  logic                 data_gnt;
  logic                 data_rvalid;
  rvfetch_pkg::beat_t   data_rdata;
  logic                 mem_req;
  rvfetch_pkg::addr_t   mem_addr;
  rvfetch_pkg::bus_id_t mem_id;
  logic                 mem_burst;
  logic                 mem_rvalid;
  rvfetch_pkg::beat_t   mem_rdata;
  rvfetch_pkg::bus_id_t mem_rid;
  logic                 mem_rlast;

  int unsigned          stim_seed  = 53872;
  int unsigned          delay_seed = 53872;
  rvfetch_pkg::addr_t   next_pc    = `RESET_PC;  // pc the stream must show next
  logic                 prev_stall = 1'b0;
  logic                 got_gnt    = 1'b0;
  logic                 got_rvalid = 1'b0;
  logic                 wrap_due   = 1'b0;
  int                   passes     = 0;
  bit                   line_seen [rvfetch_pkg::addr_t];
  int                   cycles;
  int                   dside;   // 0 idle, 1 wait grant, 2 wait data
  int                   dwait;
  int                   n_redirects;
  rvfetch_pkg::addr_t   rd_addr;
  rvfetch_pkg::bus_id_t rd_id;
  int                   rd_beats;

  tb_clock #(.HALF_NS(10), .RESET_CYCLES(3)) clkgen (.clk(clk), .rst_n(rst_n));

  rvfetch_top dut0 (.*);

  function automatic int unsigned lcg_next(inout int unsigned state);
    state = state * 32'd1103515245 + 32'd12345;
    return state >> 16;
  endfunction

  // memory contents hash the full byte address
  function automatic rvfetch_pkg::inst_t model_word(input rvfetch_pkg::addr_t a);
    return (a[31:0] * 32'h9e37_79b1) ^ a[63:32] ^ 32'h0bad_f00d;
  endfunction

  function automatic rvfetch_pkg::beat_t model_beat(input rvfetch_pkg::addr_t a);
    return {model_word(a + 4), model_word(a)};  // low half at the lower address
  endfunction

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (act === exp)
      else stop_with_error($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  // read memory with 1 to 6 cycles to the first beat
  initial begin
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    mem_rid    = '0;
    mem_rlast  = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && mem_req) begin
        rd_addr  = {mem_addr[`XLEN-1:3], 3'b000};
        rd_id    = mem_id;
        rd_beats = mem_burst ? `LINE_BEATS : 1;
        repeat (lcg_next(delay_seed) % 6) @(posedge clk);
        for (int i = 0; i < rd_beats; i++) begin
          @(posedge clk);
          mem_rvalid <= 1'b1;
          mem_rdata  <= model_beat(rd_addr + 8 * i);
          mem_rid    <= rd_id;
          mem_rlast  <= (i == rd_beats - 1);
        end
        @(posedge clk);
        mem_rvalid <= 1'b0;
        mem_rlast  <= 1'b0;
      end
    end
  end

  stall_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    stall && !redirect_valid |=> $stable(inst) && $stable(inst_pc) && $stable(inst_valid))
    else stop_with_error("inst outputs changed while stall was high");

  data_first_a : assert property (@(posedge clk) disable iff (!rst_n)
    mem_req && mem_burst |-> !$past(data_req))
    else stop_with_error("refill issued while a data request was waiting");

  // outputs are settled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (inst_valid) begin
        check_value("inst_word", model_word(inst_pc), inst);
      end else begin
        check_value("nop_bubble", `NOP_INST, inst);
      end
      if (inst_valid && !prev_stall) begin  // fresh delivery, not a held one
        check_value("inst_pc", next_pc, inst_pc);
        next_pc = next_pc + 4;
        if (inst_pc == LOOP_LAST) begin
          passes++;
          wrap_due = 1'b1;
        end
      end
      if (redirect_valid) begin
        next_pc = redirect_pc;
      end
      if (mem_req && mem_burst) begin
        check_value("burst_align", '0, mem_addr % `LINE_BYTES);
        check_value("burst_id", `ID_FETCH, mem_id);
        check_value("burst_refetch", 0, line_seen.exists(mem_addr));
        line_seen[mem_addr] = 1'b1;
      end else if (mem_req) begin
        check_value("data_id", `ID_DATA, mem_id);
      end
      if (data_rvalid) begin
        check_value("data_rdata", model_beat(data_addr), data_rdata);
      end
      prev_stall = stall;
      got_gnt    = data_gnt;
      got_rvalid = data_rvalid;
    end
  end

  initial begin
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    stall          = 1'b0;
    data_req       = 1'b0;
    data_addr      = DATA_BASE;
    cycles         = 0;
    dside          = 0;
    dwait          = 0;
    n_redirects    = 0;
    while (passes < 2) begin
      @(posedge clk);
      cycles++;
      if (cycles > MAX_CYCLES) begin
        stop_with_error("timeout, fetch loop did not finish two passes");
      end
      if (rst_n) begin
        redirect_valid <= 1'b0;
        stall          <= (lcg_next(stim_seed) % 6 == 0);
        if (wrap_due) begin
          wrap_due = 1'b0;
          redirect_valid <= 1'b1;
          redirect_pc    <= `RESET_PC;  // back to loop start
        end else if (n_redirects < MAX_REDIRECT && lcg_next(stim_seed) % 48 == 0) begin
          n_redirects++;
          redirect_valid <= 1'b1;
          redirect_pc    <= `RESET_PC + `LINE_BYTES * (lcg_next(stim_seed) % LOOP_LINES);
        end
        case (dside)
          0: begin
            if (lcg_next(stim_seed) % 20 == 0) begin
              data_req  <= 1'b1;
              data_addr <= DATA_BASE + 8 * (lcg_next(stim_seed) % 64);
              dside = 1;
              dwait = 0;
            end
          end
          1: begin
            if (got_gnt) begin
              data_req <= 1'b0;
              dside = 2;
              dwait = 0;
            end
          end
          default: begin
            if (got_rvalid) begin
              dside = 0;
            end
          end
        endcase
        if (dside != 0) begin
          dwait++;
          if (dwait > WAIT_LIMIT) begin
            stop_with_error("timeout waiting for data_gnt or data_rvalid");
          end
        end
      end
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int HALF_NS      = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;  // released on an edge
  end

  always #(HALF_NS) clk = ~clk;

endmodule

`default_nettype wire

// File: logic/rvfetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module rvfetch_top (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       redirect_valid,
  input  wire rvfetch_pkg::addr_t   redirect_pc,
  input  wire                       stall,
  output rvfetch_pkg::inst_t        inst,
  output rvfetch_pkg::addr_t        inst_pc,
  output logic                      inst_valid,
  input  wire                       data_req,
  input  wire rvfetch_pkg::addr_t   data_addr,
  output logic                      data_gnt,
  output logic                      data_rvalid,
  output rvfetch_pkg::beat_t        data_rdata,
  output logic                      mem_req,
  output rvfetch_pkg::addr_t        mem_addr,
  output rvfetch_pkg::bus_id_t      mem_id,
  output logic                      mem_burst,
  input  wire                       mem_rvalid,
  input  wire rvfetch_pkg::beat_t   mem_rdata,
  input  wire rvfetch_pkg::bus_id_t mem_rid,
  input  wire                       mem_rlast
);

  fetch_if  fetch_bus ();
  refill_if refill_bus ();

  assign fetch_bus.flush = redirect_valid;

  pc_gen u_pc_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch          (fetch_bus.pc_side),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  icache u_icache (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch      (fetch_bus.cache_side),
    .stall      (stall),
    .refill     (refill_bus.cache_side),
    .inst       (inst),
    .inst_pc    (inst_pc),
    .inst_valid (inst_valid)
  );

  mem_port u_mem_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .refill      (refill_bus.port_side),
    .data_req    (data_req),
    .data_addr   (data_addr),
    .data_gnt    (data_gnt),
    .data_rvalid (data_rvalid),
    .data_rdata  (data_rdata),
    .mem_req     (mem_req),
    .mem_addr    (mem_addr),
    .mem_id      (mem_id),
    .mem_burst   (mem_burst),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata),
    .mem_rid     (mem_rid),
    .mem_rlast   (mem_rlast)
  );

endmodule

`default_nettype wire

// File: logic/mem_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvfetch_defines.svh"

module mem_port (
  input  wire                     clk,
  input  wire                     rst_n,
  refill_if.port_side             refill,
  input  wire                     data_req,
  input  wire rvfetch_pkg::addr_t data_addr,
  output logic                    data_gnt,
  output logic                    data_rvalid,
  output rvfetch_pkg::beat_t      data_rdata,
  output logic                    mem_req,
  output rvfetch_pkg::addr_t      mem_addr,
  output rvfetch_pkg::bus_id_t    mem_id,
  output logic                    mem_burst,
  input  wire                     mem_rvalid,
  input  wire rvfetch_pkg::beat_t mem_rdata,
  input  wire rvfetch_pkg::bus_id_t mem_rid,
  input  wire                     mem_rlast
);

  logic busy;        // one transaction outstanding
  logic idle;
  logic pick_data;
  logic pick_fetch;
  logic fetch_beat;

  assign idle       = !busy && !mem_req;
  assign pick_data  = idle && data_req;   // data side wins ties
  assign pick_fetch = idle && !data_req && refill.req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      mem_req  <= 1'b0;
      data_gnt <= 1'b0;
    end else begin
      mem_req  <= pick_data || pick_fetch;
      data_gnt <= pick_data;
      if (mem_rvalid && mem_rlast) begin
        busy <= 1'b0;
      end else if (mem_req) begin
        busy <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pick_data) begin
      mem_addr  <= data_addr;
      mem_id    <= `ID_DATA;
      mem_burst <= 1'b0;
    end else if (pick_fetch) begin
      mem_addr  <= refill.addr;
      mem_id    <= `ID_FETCH;
      mem_burst <= 1'b1;  // whole line
    end
  end

  // route returned beats by id
  assign fetch_beat        = mem_rvalid && (mem_rid == `ID_FETCH);
  assign refill.beat       = mem_rdata;
  assign refill.beat_valid = fetch_beat;
  assign refill.last       = fetch_beat && mem_rlast;

  assign data_rvalid = mem_rvalid && (mem_rid == `ID_DATA);
  assign data_rdata  = mem_rdata;

  no_req_busy_a : assert property (
    @(posedge clk) disable iff (!rst_n)
      mem_req |-> !busy)
    else $error("mem_req issued while a transaction is outstanding");

  // memory answers only what was asked
  no_stray_beat_a : assert property (
    @(posedge clk) disable iff (!rst_n)
      mem_rvalid |-> busy)
    else $error("read beat with nothing outstanding");

endmodule

`default_nettype wire

// File: logic/icache.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvfetch_defines.svh"

module icache (
  input  wire                clk,
  input  wire                rst_n,
  fetch_if.cache_side        fetch,
  input  wire                stall,
  refill_if.cache_side       refill,
  output rvfetch_pkg::inst_t inst,
  output rvfetch_pkg::addr_t inst_pc,
  output logic               inst_valid
);

  localparam int OFFS_W  = $clog2(`LINE_BYTES);
  localparam int INDEX_W = $clog2(`NUM_SETS);
  localparam int TAG_W   = `XLEN - OFFS_W - INDEX_W;
  localparam int BEAT_W  = $clog2(`LINE_BEATS);

  // storage
  logic [TAG_W-1:0]   tag_mem [`NUM_SETS];
  logic [`NUM_SETS-1:0] valid_bits;
  rvfetch_pkg::beat_t data_mem [`NUM_SETS][`LINE_BEATS];

  rvfetch_pkg::cache_state_e state;
  rvfetch_pkg::addr_t lk_pc;      // pc under lookup
  logic               lk_valid;
  rvfetch_pkg::addr_t fill_addr;
  logic               fill_req;
  logic [BEAT_W-1:0]  beat_cnt;
  rvfetch_pkg::inst_t inst_q;

  logic [INDEX_W-1:0] lk_idx;
  logic [TAG_W-1:0]   lk_tag;
  logic [INDEX_W-1:0] fill_idx;
  rvfetch_pkg::beat_t lk_beat;
  rvfetch_pkg::inst_t lk_word;
  logic               hit;
  logic               miss;
  logic               refilling;
  logic               accept;
  logic               deliver;

  assign lk_idx   = lk_pc[OFFS_W +: INDEX_W];
  assign lk_tag   = lk_pc[`XLEN-1 -: TAG_W];
  assign fill_idx = fill_addr[OFFS_W +: INDEX_W];

  assign hit  = valid_bits[lk_idx] && (tag_mem[lk_idx] == lk_tag);
  assign miss = lk_valid && !hit;

  // beat by pc[4:3], then half by pc[2]
  assign lk_beat = data_mem[lk_idx][lk_pc[OFFS_W-1:3]];
  assign lk_word = lk_pc[2] ? lk_beat[2*`INST_W-1:`INST_W] : lk_beat[`INST_W-1:0];

  assign refilling  = (state == rvfetch_pkg::REFILL);
  assign fetch.hold = stall || miss || refilling;

  assign accept  = fetch.pc_valid && !fetch.hold && !fetch.flush;
  assign deliver = lk_valid && hit && !stall && !fetch.flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= rvfetch_pkg::IDLE;
      valid_bits <= '0;
      lk_valid   <= 1'b0;
      fill_req   <= 1'b0;
      beat_cnt   <= '0;
      inst_valid <= 1'b0;
      inst_pc    <= '0;
    end else begin
      // lookup slot and output register
      if (fetch.flush) begin
        lk_valid   <= 1'b0;
        inst_valid <= 1'b0;   // in-flight instruction dropped
      end else begin
        if (accept) begin
          lk_valid <= 1'b1;
        end else if (deliver) begin
          lk_valid <= 1'b0;
        end
        if (!stall) begin
          inst_valid <= deliver;
        end
      end
      if (deliver) begin
        inst_pc <= lk_pc;
      end

      case (state)
        rvfetch_pkg::IDLE: begin
          if (miss) begin
            state              <= rvfetch_pkg::REFILL;
            fill_req           <= 1'b1;
            beat_cnt           <= '0;
            valid_bits[lk_idx] <= 1'b0;  // line is being replaced
          end
        end
        rvfetch_pkg::REFILL: begin
          if (refill.beat_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
          if (refill.last) begin
            fill_req             <= 1'b0;
            valid_bits[fill_idx] <= 1'b1;
            state                <= rvfetch_pkg::DONE;
          end
        end
        rvfetch_pkg::DONE: state <= rvfetch_pkg::IDLE;  // lookup hits now
        default:           state <= rvfetch_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      lk_pc <= fetch.pc;
    end
    if (state == rvfetch_pkg::IDLE && miss) begin
      fill_addr <= {lk_pc[`XLEN-1:OFFS_W], {OFFS_W{1'b0}}};
    end
    if (deliver) begin
      inst_q <= lk_word;
    end
    if (refilling && refill.beat_valid) begin
      data_mem[fill_idx][beat_cnt] <= refill.beat;
    end
    if (refilling && refill.last) begin
      tag_mem[fill_idx] <= fill_addr[`XLEN-1 -: TAG_W];
    end
  end

  assign refill.req  = fill_req;
  assign refill.addr = fill_addr;

  // bubble whenever nothing valid
  assign inst = inst_valid ? inst_q : `NOP_INST;

  refill_aligned_a : assert property (
    @(posedge clk) disable iff (!rst_n)
      refill.req |-> refill.addr[OFFS_W-1:0] == '0)
    else $error("refill address not line aligned");

  // last comes from the memory port
  refill_last_a : assert property (
    @(posedge clk) disable iff (!rst_n)
      refill.last |-> refill.req)
    else $error("refill last seen without a pending request");

endmodule

`default_nettype wire

// File: logic/pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvfetch_defines.svh"

module pc_gen (
  input  wire                clk,
  input  wire                rst_n,
  fetch_if.pc_side           fetch,
  input  wire                redirect_valid,
  input  wire rvfetch_pkg::addr_t redirect_pc
);

  localparam rvfetch_pkg::addr_t STEP = rvfetch_pkg::addr_t'(`INST_W / 8);

  rvfetch_pkg::addr_t pc_q;
  logic               pc_valid_q;
  logic               accept;

  // the cache takes the pc whenever it is not holding
  assign accept = pc_valid_q && !fetch.hold;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q       <= `RESET_PC;
      pc_valid_q <= 1'b0;
    end else begin
      pc_valid_q <= 1'b1;  // valid from the first cycle out of reset
      if (redirect_valid) begin
        pc_q <= redirect_pc;  // redirect beats everything
      end else if (accept) begin
        pc_q <= pc_q + STEP;
      end
    end
  end

  assign fetch.pc       = pc_q;
  assign fetch.pc_valid = pc_valid_q;

  // pc must not move under a hold from the cache stage
  property pc_held_p;
    @(posedge clk) disable iff (!rst_n)
      fetch.pc_valid && fetch.hold && !redirect_valid |=> $stable(fetch.pc);
  endproperty

  pc_held_a : assert property (pc_held_p)
    else $error("pc changed while hold was high");

endmodule

`default_nettype wire

// File: logic/refill_if.sv
`timescale 1ns/10ps
`default_nettype none

interface refill_if;

  logic               req;         // level until last
  rvfetch_pkg::addr_t addr;        // line aligned
  rvfetch_pkg::beat_t beat;
  logic               beat_valid;
  logic               last;

  modport cache_side (
    output req,
    output addr,
    input  beat,
    input  beat_valid,
    input  last
  );

  modport port_side (
    input  req,
    input  addr,
    output beat,
    output beat_valid,
    output last
  );

endinterface

`default_nettype wire

// File: logic/fetch_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fetch_if;

  rvfetch_pkg::addr_t pc;
  logic               pc_valid;
  logic               hold;   // cache busy or downstream stall
  logic               flush;  // from redirect

  modport pc_side (
    output pc,
    output pc_valid,
    input  hold
  );

  modport cache_side (
    input  pc,
    input  pc_valid,
    output hold,
    input  flush
  );

endinterface

`default_nettype wire

// File: logic/rvfetch_pkg.sv
`default_nettype none

`include "rvfetch_defines.svh"

package rvfetch_pkg;

  // fetch address, one word
  typedef logic [`XLEN-1:0] addr_t;

  // one bus data beat
  typedef logic [`XLEN-1:0] beat_t;

  typedef logic [`INST_W-1:0] inst_t;

  // request id on the external read bus
  typedef logic [3:0] bus_id_t;

  // miss handling in the cache stage
  typedef enum logic [1:0] {
    IDLE,
    REFILL,
    DONE    // one cycle to replay the missed pc
  } cache_state_e;

endpackage

`default_nettype wire

// File: logic/rvfetch_defines.svh
`ifndef RVFETCH_DEFINES_SVH
`define RVFETCH_DEFINES_SVH

// datapath widths
`define XLEN       64
`define INST_W     32

// first fetch after reset
`define RESET_PC   64'h0000_0000_8000_0000

// cache geometry, 64-bit beats
`define LINE_BEATS 4
`define LINE_BYTES (`LINE_BEATS * 8)
`define NUM_SETS   16

// external bus ids
`define ID_FETCH   4'd1
`define ID_DATA    4'd2

// addi x0, x0, 0
`define NOP_INST   32'h0000_0013

`endif
